// File: source/fpu_pkg.sv
//--------------------------------------
// FP execution stage package
// Widths, encodings and bus types shared by
// the decoder, both units and the queue
//--------------------------------------
package fpu_pkg;

   localparam int XLEN        = 32;
   localparam int TAG_W       = 2;
   localparam int QUEUE_DEPTH = 2 ** TAG_W;
   localparam int REG_W       = 5;

   //--------------------------------------
   // Unit sub-operation codes (unit_req_t.sub)
   //--------------------------------------
   localparam logic [2:0] SUB_SGNJ   = 3'd0;
   localparam logic [2:0] SUB_MINMAX = 3'd1;
   localparam logic [2:0] SUB_CMP    = 3'd2;
   localparam logic [2:0] SUB_CLASS  = 3'd3;
   localparam logic [2:0] SUB_MV     = 3'd4;
   localparam logic [2:0] SUB_I2F    = 3'd5;

   // funct3 modifiers of the noncomp group
   localparam logic [2:0] F3_FSGNJ  = 3'b000;
   localparam logic [2:0] F3_FSGNJN = 3'b001;
   localparam logic [2:0] F3_FSGNJX = 3'b010;
   localparam logic [2:0] F3_FMIN   = 3'b000;
   localparam logic [2:0] F3_FLE    = 3'b000;
   localparam logic [2:0] F3_FLT    = 3'b001;
   localparam logic [2:0] F3_FEQ    = 3'b010;

   localparam logic [XLEN-1:0] CANON_NAN   = 32'h7fc0_0000;
   localparam logic [7:0]      I2F_EXP_MAX = 8'd158;   // Bias plus 31

   typedef enum logic [2:0] {
      SGNJ,
      MINMAX,
      CMP,
      CLASS,
      CVT_I2F,
      MV_X2F
   } fpu_op_e;

   typedef enum logic [2:0] {
      RNE = 3'b000,
      RTZ = 3'b001
   } round_e;

   typedef struct packed {
      logic nv;
      logic dz;
      logic of;
      logic uf;
      logic nx;
   } fp_status_t;

   typedef struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
   } fp32_t;

   // One operand word, read as float fields or as an integer
   typedef union packed {
      fp32_t           f;
      logic [XLEN-1:0] i;
   } fp_word_u;

   typedef struct packed {
      logic             valid;
      fpu_op_e          op;
      logic [2:0]       funct3;       // Sub-operation or frm
      logic             is_unsigned;
      logic [REG_W-1:0] rd;
      logic             int_we;       // Result goes to integer file
      fp_word_u         data_rs1;
      fp_word_u         data_rs2;
   } fpu_instr_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
      logic [2:0]       sub;
      round_e           rnd;
      logic             is_unsigned;
      fp_word_u         a;
      fp_word_u         b;
   } unit_req_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  data;
      fp_status_t       status;
   } unit_res_t;

   typedef struct packed {
      logic             valid;
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  result;
      fp_status_t       fp_status;
   } fp_wb_t;

   typedef struct packed {
      logic             valid;
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  result;
      fp_status_t       fp_status;
   } int_wb_t;

endpackage

// File: source/fpu_decoder.sv
//--------------------------------------
// FP instruction decoder
// Selects the unit and builds its request
//--------------------------------------
`timescale 1ns/10ps

module fpu_decoder (
   input  fpu_pkg::fpu_instr_t       instr_i,
   input  logic [fpu_pkg::TAG_W-1:0] tag_i,
   input  logic                      stall_i,
   output fpu_pkg::unit_req_t        noncomp_req_o,
   output fpu_pkg::unit_req_t        i2f_req_o
);
   import fpu_pkg::*;

   logic       accept;
   logic       to_i2f;
   logic [2:0] sub;
   round_e     rnd;
   unit_req_t  req;

   assign accept = instr_i.valid & ~stall_i;

   //--------------------------------------
   // Operation to unit mapping
   //--------------------------------------
   always_comb begin
      to_i2f = 1'b0;
      sub    = SUB_MV;
      // Noncomp ops take funct3 unchanged as modifier
      rnd    = round_e'(instr_i.funct3);
      case (instr_i.op)
         SGNJ:    sub = SUB_SGNJ;
         MINMAX:  sub = SUB_MINMAX;
         CMP:     sub = SUB_CMP;
         CLASS:   sub = SUB_CLASS;
         CVT_I2F: begin
            to_i2f = 1'b1;
            sub    = SUB_I2F;
            // Only RTZ kept, everything else rounds to nearest even
            rnd    = (instr_i.funct3 == RTZ) ? RTZ : RNE;
         end
         MV_X2F:  sub = SUB_MV;       // Raw pass-through
         default: sub = SUB_MV;
      endcase
   end

   always_comb begin
      req.valid       = 1'b0;
      req.tag         = tag_i;
      req.sub         = sub;
      req.rnd         = rnd;
      req.is_unsigned = instr_i.is_unsigned;
      req.a           = instr_i.data_rs1;
      req.b           = instr_i.data_rs2;
   end

   // Same payload to both units, valid only on the selected one
   always_comb begin
      noncomp_req_o       = req;
      noncomp_req_o.valid = accept & ~to_i2f;
      i2f_req_o           = req;
      i2f_req_o.valid     = accept & to_i2f;
   end

endmodule

// File: source/fpu_noncomp.sv
//--------------------------------------
// Non-computational FP unit
// Sign injection, min/max, compare,
// classify and move in one stage
//--------------------------------------
`timescale 1ns/10ps

module fpu_noncomp (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               kill_i,
   input  fpu_pkg::unit_req_t req_i,
   output fpu_pkg::unit_res_t res_o
);
   import fpu_pkg::*;

   fp_word_u        a;
   fp_word_u        b;
   logic [2:0]      fn;
   logic            a_nan, b_nan, a_snan, b_snan;
   logic            a_inf, a_zero, a_sub, a_norm, a_qnan;
   logic            b_zero, any_nan, both_zero;
   logic            raw_lt, feq, flt, fle;
   logic [9:0]      cls;
   logic [XLEN-1:0] res_d;
   fp_status_t      st_d;
   unit_res_t       res_q;

   assign a  = req_i.a;
   assign b  = req_i.b;
   assign fn = req_i.rnd;

   // Operand classes
   assign a_nan  = (a.f.exp == 8'hff) & (a.f.man != '0);
   assign b_nan  = (b.f.exp == 8'hff) & (b.f.man != '0);
   assign a_snan = a_nan & ~a.f.man[22];
   assign b_snan = b_nan & ~b.f.man[22];
   assign a_qnan = a_nan & a.f.man[22];
   assign a_inf  = (a.f.exp == 8'hff) & (a.f.man == '0);
   assign a_zero = (a.f.exp == 8'h00) & (a.f.man == '0);
   assign a_sub  = (a.f.exp == 8'h00) & (a.f.man != '0);
   assign a_norm = (a.f.exp != 8'h00) & (a.f.exp != 8'hff);
   assign b_zero = (b.f.exp == 8'h00) & (b.f.man == '0);

   assign any_nan   = a_nan | b_nan;
   assign both_zero = a_zero & b_zero;

   // Ordering with -0 below +0, NaNs ignored
   assign raw_lt = (a.f.sign != b.f.sign) ? a.f.sign :
                   a.f.sign ? (a.i[30:0] > b.i[30:0]) : (a.i[30:0] < b.i[30:0]);

   assign feq = ~any_nan & ((a.i == b.i) | both_zero);
   assign flt = ~any_nan & raw_lt & ~both_zero;
   assign fle = flt | feq;

   assign cls = {a_qnan, a_snan,
                 ~a.f.sign & a_inf, ~a.f.sign & a_norm, ~a.f.sign & a_sub, ~a.f.sign & a_zero,
                 a.f.sign & a_zero, a.f.sign & a_sub, a.f.sign & a_norm, a.f.sign & a_inf};

   always_comb begin
      res_d = a.i;
      st_d  = '0;
      case (req_i.sub)
         SUB_SGNJ: begin
            case (fn)
               F3_FSGNJ:  res_d = {b.f.sign, a.i[30:0]};
               F3_FSGNJN: res_d = {~b.f.sign, a.i[30:0]};
               F3_FSGNJX: res_d = {a.f.sign ^ b.f.sign, a.i[30:0]};
               default:   res_d = a.i;
            endcase
         end
         SUB_MINMAX: begin
            st_d.nv = a_snan | b_snan;
            if (a_nan & b_nan)     res_d = CANON_NAN;
            else if (a_nan)        res_d = b.i;
            else if (b_nan)        res_d = a.i;
            else if (fn == F3_FMIN) res_d = raw_lt ? a.i : b.i;
            else                   res_d = raw_lt ? b.i : a.i;
         end
         SUB_CMP: begin
            case (fn)
               F3_FEQ: begin
                  res_d   = {{(XLEN-1){1'b0}}, feq};
                  st_d.nv = a_snan | b_snan;   // Quiet compare
               end
               F3_FLT: begin
                  res_d   = {{(XLEN-1){1'b0}}, flt};
                  st_d.nv = any_nan;
               end
               F3_FLE: begin
                  res_d   = {{(XLEN-1){1'b0}}, fle};
                  st_d.nv = any_nan;
               end
               default: res_d = '0;
            endcase
         end
         SUB_CLASS: res_d = {{(XLEN-10){1'b0}}, cls};
         default:   res_d = a.i;               // Move
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i | kill_i) res_q.valid <= 1'b0;
      else                res_q.valid <= req_i.valid;
      res_q.tag    <= req_i.tag;
      res_q.data   <= res_d;
      res_q.status <= st_d;
   end

   assign res_o = res_q;

   // Flushed ops must not reach the queue
   a_no_res_after_kill: assert property (@(posedge clk_i) disable iff (rst_i)
      kill_i |=> !res_o.valid);

endmodule

// File: source/fpu_i2f.sv
//--------------------------------------
// Integer to FP32 converter
// One normalise shift per cycle, then
// a single RNE/RTZ rounding cycle
//--------------------------------------
`timescale 1ns/10ps

module fpu_i2f (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               kill_i,
   input  fpu_pkg::unit_req_t req_i,
   output logic               busy_o,
   output fpu_pkg::unit_res_t res_o
);
   import fpu_pkg::*;

   typedef enum logic [1:0] {IDLE, NORM, ROUND} state_e;

   state_e           state_q;
   logic [XLEN-1:0]  mag_q;
   logic [7:0]       exp_q;
   logic             sign_q;
   round_e           rnd_q;
   logic [TAG_W-1:0] tag_q;
   logic             neg_in;
   logic [XLEN-1:0]  mag_in;
   logic             zero, guard, sticky, round_up;
   logic [24:0]      man_rnd;
   logic [7:0]       exp_rnd;
   fp_status_t       st;
   unit_res_t        res_q;

   assign neg_in = ~req_i.is_unsigned & req_i.a.i[XLEN-1];
   assign mag_in = neg_in ? (~req_i.a.i + 1'b1) : req_i.a.i;

   //--------------------------------------
   // Rounding of the normalised magnitude
   //--------------------------------------
   assign zero     = (mag_q == '0);
   assign guard    = mag_q[7];
   assign sticky   = |mag_q[6:0];
   assign round_up = (rnd_q == RNE) & guard & (sticky | mag_q[8]);
   assign man_rnd  = {1'b0, mag_q[31:8]} + {24'd0, round_up};
   assign exp_rnd  = exp_q + {7'd0, man_rnd[24]};   // Carry out bumps exponent

   always_comb begin
      st    = '0;
      st.nx = guard | sticky;
   end

   // Magnitude and exponent datapath
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && req_i.valid) begin
         mag_q  <= mag_in;
         exp_q  <= I2F_EXP_MAX;
         sign_q <= neg_in;
         rnd_q  <= req_i.rnd;
         tag_q  <= req_i.tag;
      end else if (state_q == NORM && !mag_q[XLEN-1] && !zero) begin
         mag_q <= mag_q << 1;
         exp_q <= exp_q - 8'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i | kill_i) begin
         state_q     <= IDLE;
         res_q.valid <= 1'b0;
      end else begin
         res_q.valid <= 1'b0;
         case (state_q)
            IDLE:  if (req_i.valid) state_q <= NORM;
            NORM:  if (mag_q[XLEN-1] | zero) state_q <= ROUND;
            ROUND: begin
               state_q      <= IDLE;
               res_q.valid  <= 1'b1;
               res_q.tag    <= tag_q;
               res_q.data   <= zero ? '0 : {sign_q, exp_rnd, man_rnd[22:0]};
               res_q.status <= st;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign busy_o = (state_q != IDLE);
   assign res_o  = res_q;

   // Issue side must hold conversions back while busy
   a_no_req_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i.valid |-> !busy_o);

endmodule

// File: source/pending_fp_ops_queue.sv
//--------------------------------------
// Pending FP operations queue
// Hands out tags, collects results out of
// order and retires them in program order
//--------------------------------------
`timescale 1ns/10ps

module pending_fp_ops_queue (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      kill_i,
   input  logic                      alloc_i,
   input  logic [fpu_pkg::REG_W-1:0] rd_i,
   input  logic                      int_we_i,
   input  fpu_pkg::unit_res_t        res_a_i,
   input  fpu_pkg::unit_res_t        res_b_i,
   input  logic                      stall_wb_i,
   output logic [fpu_pkg::TAG_W-1:0] tag_o,
   output logic                      full_o,
   output fpu_pkg::fp_wb_t           fp_wb_o,
   output fpu_pkg::int_wb_t          int_wb_o
);
   import fpu_pkg::*;

   typedef struct packed {
      logic [REG_W-1:0] rd;
      logic             int_we;
      logic [XLEN-1:0]  data;
      fp_status_t       status;
   } entry_t;

   entry_t                 entries_q [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] alloc_q;
   logic [QUEUE_DEPTH-1:0] done_q;
   logic [TAG_W-1:0]       head_q;
   logic [TAG_W-1:0]       tail_q;
   logic [TAG_W:0]         count_q;
   logic                   wr_a, wr_b;
   logic                   show, retire;
   entry_t                 head;

   // Writes to freed entries are dropped
   assign wr_a = res_a_i.valid & alloc_q[res_a_i.tag];
   assign wr_b = res_b_i.valid & alloc_q[res_b_i.tag];

   assign head   = entries_q[head_q];
   assign show   = alloc_q[head_q] & done_q[head_q];
   assign retire = show & ~stall_wb_i;

   //--------------------------------------
   // Pointers and entry flags
   //--------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i | kill_i) begin
         alloc_q <= '0;
         done_q  <= '0;
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         if (alloc_i) begin
            alloc_q[tail_q] <= 1'b1;
            done_q[tail_q]  <= 1'b0;
            tail_q          <= tail_q + 1'b1;
         end
         if (wr_a) done_q[res_a_i.tag] <= 1'b1;
         if (wr_b) done_q[res_b_i.tag] <= 1'b1;
         if (retire) begin
            alloc_q[head_q] <= 1'b0;
            done_q[head_q]  <= 1'b0;
            head_q          <= head_q + 1'b1;
         end
         count_q <= count_q + (TAG_W+1)'(alloc_i) - (TAG_W+1)'(retire);
      end
   end

   // Entry payload, two result write ports
   always_ff @(posedge clk_i) begin
      if (alloc_i) begin
         entries_q[tail_q].rd     <= rd_i;
         entries_q[tail_q].int_we <= int_we_i;
      end
      if (wr_a) begin
         entries_q[res_a_i.tag].data   <= res_a_i.data;
         entries_q[res_a_i.tag].status <= res_a_i.status;
      end
      if (wr_b) begin
         entries_q[res_b_i.tag].data   <= res_b_i.data;
         entries_q[res_b_i.tag].status <= res_b_i.status;
      end
   end

   assign tag_o  = tail_q;
   assign full_o = (count_q == (TAG_W+1)'(QUEUE_DEPTH));

   //--------------------------------------
   // Writeback ports, picked by stored int_we
   //--------------------------------------
   assign fp_wb_o.valid     = show & ~head.int_we;
   assign fp_wb_o.rd        = head.rd;
   assign fp_wb_o.result    = head.data;
   assign fp_wb_o.fp_status = head.status;

   assign int_wb_o.valid     = show & head.int_we;
   assign int_wb_o.rd        = head.rd;
   assign int_wb_o.result    = head.data;
   assign int_wb_o.fp_status = head.status;

   a_no_alloc_full: assert property (@(posedge clk_i) disable iff (rst_i)
      alloc_i |-> !full_o);

   // Units only return results for live tags
   a_res_allocated: assert property (@(posedge clk_i) disable iff (rst_i)
      !((res_a_i.valid && !alloc_q[res_a_i.tag]) || (res_b_i.valid && !alloc_q[res_b_i.tag])));

endmodule

// File: source/fpu_wrapper.sv
//--------------------------------------
// FP execution stage top level
// Decoder, noncomp unit, converter and
// the in-order retire queue
//--------------------------------------
`timescale 1ns/10ps

module fpu_wrapper (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                kill_i,
   input  logic                stall_wb_i,
   input  fpu_pkg::fpu_instr_t instruction_i,
   output fpu_pkg::fp_wb_t     fp_wb_o,
   output fpu_pkg::int_wb_t    int_wb_o,
   output logic                stall_o
);
   import fpu_pkg::*;

   logic [TAG_W-1:0] tag;
   logic             queue_full;
   logic             i2f_busy;
   logic             alloc;
   unit_req_t        noncomp_req;
   unit_req_t        i2f_req;
   unit_res_t        noncomp_res;
   unit_res_t        i2f_res;

   // Full queue, or a conversion waiting on a busy converter
   assign stall_o = queue_full |
                    (instruction_i.valid & (instruction_i.op == CVT_I2F) & i2f_busy);

   assign alloc = noncomp_req.valid | i2f_req.valid;   // Accepted this cycle

   fpu_decoder fpu_decoder_inst (
      .instr_i       (instruction_i),
      .tag_i         (tag),
      .stall_i       (stall_o),
      .noncomp_req_o (noncomp_req),
      .i2f_req_o     (i2f_req)
   );

   fpu_noncomp fpu_noncomp_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .kill_i (kill_i),
      .req_i  (noncomp_req),
      .res_o  (noncomp_res)
   );

   fpu_i2f fpu_i2f_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .kill_i (kill_i),
      .req_i  (i2f_req),
      .busy_o (i2f_busy),
      .res_o  (i2f_res)
   );

   pending_fp_ops_queue pending_fp_ops_queue_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .kill_i     (kill_i),
      .alloc_i    (alloc),
      .rd_i       (instruction_i.rd),
      .int_we_i   (instruction_i.int_we),
      .res_a_i    (noncomp_res),
      .res_b_i    (i2f_res),
      .stall_wb_i (stall_wb_i),
      .tag_o      (tag),
      .full_o     (queue_full),
      .fp_wb_o    (fp_wb_o),
      .int_wb_o   (int_wb_o)
   );

endmodule

// File: tests/fpu_ref.svh
//--------------------------------------
// Reference model for the FP stage
// Expected result and flags of one
// issued instruction
//--------------------------------------
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

typedef struct packed {
   logic             int_we;
   logic [REG_W-1:0] rd;
   logic [XLEN-1:0]  result;
   fp_status_t       status;
} expect_t;

function automatic logic is_nan(input fp_word_u w);
   return (w.f.exp == 8'hff) && (w.f.man != 23'd0);
endfunction

function automatic logic is_snan(input fp_word_u w);
   return is_nan(w) && !w.f.man[22];
endfunction

// Unsigned key in numeric order, -0 sits just below +0
function automatic logic [XLEN-1:0] order_key(input fp_word_u w);
   return w.f.sign ? ~w.i : {1'b1, w.i[30:0]};
endfunction

function automatic expect_t ref_result(input fpu_instr_t ins);
   expect_t     e;
   fp_word_u    a;
   fp_word_u    b;
   logic [2:0]  f3;
   logic        nan_ab;
   logic        zeros;
   logic        eq;
   logic        lt;
   logic        neg;
   logic [63:0] mag;
   logic [63:0] kept;
   logic [63:0] rem;
   logic [63:0] half;
   logic [63:0] bits;
   int          p;
   int          sh;
   int          kind;

   a        = ins.data_rs1;
   b        = ins.data_rs2;
   f3       = ins.funct3;
   e        = '0;
   e.int_we = ins.int_we;
   e.rd     = ins.rd;
   nan_ab   = is_nan(a) || is_nan(b);
   zeros    = (a.i[30:0] == 31'd0) && (b.i[30:0] == 31'd0);
   eq       = !nan_ab && ((a.i == b.i) || zeros);
   lt       = !nan_ab && !zeros && (order_key(a) < order_key(b));
   case (ins.op)
      SGNJ:
         case (f3)
            3'd0:    e.result = {b.f.sign, a.i[30:0]};
            3'd1:    e.result = {~b.f.sign, a.i[30:0]};
            default: e.result = {a.f.sign ^ b.f.sign, a.i[30:0]};
         endcase
      MINMAX: begin
         e.status.nv = is_snan(a) || is_snan(b);
         if (is_nan(a) && is_nan(b))
            e.result = 32'h7fc0_0000;
         else if (is_nan(a) || is_nan(b))
            e.result = is_nan(a) ? b.i : a.i;   // The number wins over a NaN
         else
            e.result = ((order_key(a) < order_key(b)) == (f3 == 3'd0)) ? a.i : b.i;
      end
      CMP: begin
         e.result    = {31'd0, (f3 == 3'd2) ? eq : (f3 == 3'd1) ? lt : (lt || eq)};
         e.status.nv = (f3 == 3'd2) ? (is_snan(a) || is_snan(b)) : nan_ab;
      end
      CLASS: begin
         if (is_nan(a)) begin
            e.result = a.f.man[22] ? 32'h200 : 32'h100;
         end else begin
            // Inf, normal, subnormal, zero
            kind = (a.f.exp == 8'hff) ? 0 : (a.f.exp != 8'h00) ? 1 :
                   (a.f.man != 23'd0) ? 2 : 3;
            e.result = 32'd1 << (a.f.sign ? kind : 7 - kind);
         end
      end
      CVT_I2F: begin
         neg = !ins.is_unsigned && a.i[31];
         mag = {32'd0, a.i};
         if (neg)
            mag = 64'h1_0000_0000 - mag;
         p = 31;
         while (p > 0 && !mag[p])
            p--;
         sh   = (p > 23) ? p - 23 : 0;
         kept = (p > 23) ? (mag >> sh) : (mag << (23 - p));
         rem  = mag & ((64'd1 << sh) - 64'd1);   // Bits lost below the mantissa
         half = (64'd1 << sh) >> 1;
         e.status.nx = (rem != 64'd0);
         // Only frm 001 truncates
         if (f3 != 3'd1 && (rem > half || (rem == half && half != 0 && kept[0])))
            kept = kept + 64'd1;
         bits     = (64'(127 + p) << 23) + kept - 64'h80_0000;
         e.result = (mag == 64'd0) ? 32'd0 : {neg, bits[30:0]};
      end
      default: e.result = a.i;   // Move
   endcase
   return e;
endfunction

`endif

// File: tests/fpu_wrapper_tb.sv
//--------------------------------------
// Testbench for the FP execution stage
// Random and directed issue, in-order
// scoreboard against a reference model
//--------------------------------------
`timescale 1ns/10ps

module fpu_wrapper_tb;
   import fpu_pkg::*;

   `include "fpu_ref.svh"

   logic       clk = 1'b0;
   logic       rst;
   logic       kill;
   logic       stall_wb;
   fpu_instr_t instr;
   fp_wb_t     fp_wb;
   int_wb_t    int_wb;
   logic       stall;

   expect_t    exp_q [$];      // Program order
   int         seed        = 21;
   int         issued      = 0;
   int         retired     = 0;
   int         flushed     = 0;
   int         flush_start = 0;
   int         cycles      = 0;
   int         wb_mode     = 0;  // 0 free, 1 random stall, 2 held
   logic       saw_stall   = 1'b0;
   logic       hold_chk    = 1'b0;
   fp_wb_t     held_fp;
   int_wb_t    held_int;

   logic [31:0] specials [12] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000,
      32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001, 32'hffc0_0001, 32'h0000_0001,
      32'h807f_ffff, 32'h3f80_0000, 32'hbf80_0000, 32'h4049_0fdb};
   logic [31:0] cvt_vals [10] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
      32'h8000_0000, 32'h7fff_ffff, 32'h0100_0001, 32'h0100_0003, 32'h00ff_ffff,
      32'h1234_5678, 32'hffff_fffe};
   fpu_op_e     nc_ops [5]  = '{SGNJ, MINMAX, CMP, CLASS, MV_X2F};

   always #50 clk = ~clk;

   fpu_wrapper UUT (
      .clk_i         (clk),
      .rst_i         (rst),
      .kill_i        (kill),
      .stall_wb_i    (stall_wb),
      .instruction_i (instr),
      .fp_wb_o       (fp_wb),
      .int_wb_o      (int_wb),
      .stall_o       (stall)
   );

   //--------------------------------------
   // Helpers
   //--------------------------------------
   task automatic fail_run;
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_fp_wb(input fp_wb_t got, input fp_wb_t want);
      if (got !== want) begin
         $display("[ERROR] fp_wb_o valid rd result status = %h %h %h %h, expected %h %h %h %h",
                  got.valid, got.rd, got.result, got.fp_status,
                  want.valid, want.rd, want.result, want.fp_status);
         fail_run();
      end
   endtask

   task automatic check_int_wb(input int_wb_t got, input int_wb_t want);
      if (got !== want) begin
         $display("[ERROR] int_wb_o valid rd result status = %h %h %h %h, expected %h %h %h %h",
                  got.valid, got.rd, got.result, got.fp_status,
                  want.valid, want.rd, want.result, want.fp_status);
         fail_run();
      end
   endtask

   function automatic logic [31:0] pick_operand();
      int k;
      k = {$random(seed)} % 12;
      if (1'($random(seed)))
         return specials[k];
      return $random(seed);
   endfunction

   // Holds the instruction until accepted, returns before the accepting edge
   task automatic issue(input fpu_op_e op, input logic [2:0] f3, input logic uns,
                        input logic [31:0] a, input logic [31:0] b);
      fpu_instr_t ins;
      ins             = '0;
      ins.valid       = 1'b1;
      ins.op          = op;
      ins.funct3      = f3;
      ins.is_unsigned = uns;
      ins.rd          = 5'($random(seed));
      ins.int_we      = (op == CMP) || (op == CLASS);
      ins.data_rs1.i  = a;
      ins.data_rs2.i  = b;
      @(posedge clk);
      instr <= ins;
      @(negedge clk);
      while (stall) begin
         saw_stall = 1'b1;
         @(negedge clk);
      end
      exp_q.push_back(ref_result(ins));
      issued++;
   endtask

   task automatic issue_random_noncomp;
      fpu_op_e    op;
      logic [2:0] f3;
      op = nc_ops[{$random(seed)} % 5];
      f3 = 3'({$random(seed)} % ((op == MINMAX) ? 2 : 3));
      issue(op, f3, 1'b0, pick_operand(), pick_operand());
   endtask

   task automatic issue_random_cvt;
      logic [31:0] v;
      v = $random(seed) >> ({$random(seed)} % 32);   // Spread of latencies
      issue(CVT_I2F, 3'($random(seed)), 1'($random(seed)), v, 32'd0);
   endtask

   task automatic go_idle;
      @(posedge clk);
      instr.valid <= 1'b0;
   endtask

   task automatic drain;
      while (exp_q.size() != 0)
         @(negedge clk);
   endtask

   //--------------------------------------
   // Writeback back-pressure
   //--------------------------------------
   always @(posedge clk) begin
      case (wb_mode)
         1:       stall_wb <= 1'($random(seed));
         2:       stall_wb <= 1'b1;
         default: stall_wb <= 1'b0;
      endcase
   end

   // Scoreboard, one pop per retiring edge
   always @(negedge clk) begin : compare_wb
      expect_t e;
      fp_wb_t  ef;
      int_wb_t ei;
      if (!rst && !kill) begin
         if (hold_chk) begin
            check_fp_wb(fp_wb, held_fp);
            check_int_wb(int_wb, held_int);
         end
         if (fp_wb.valid && int_wb.valid) begin
            $display("Both writeback ports were valid in the same cycle");
            fail_run();
         end
         if ((fp_wb.valid || int_wb.valid) && exp_q.size() == 0) begin
            $display("A writeback was shown with no instruction outstanding");
            fail_run();
         end
         if ((fp_wb.valid || int_wb.valid) && !stall_wb) begin
            e  = exp_q.pop_front();
            ef = '{valid: !e.int_we, rd: e.rd, result: e.result, fp_status: e.status};
            ei = '{valid: e.int_we, rd: e.rd, result: e.result, fp_status: e.status};
            retired++;
            if (e.int_we)
               check_int_wb(int_wb, ei);
            else
               check_fp_wb(fp_wb, ef);
         end
         hold_chk = (fp_wb.valid || int_wb.valid) && stall_wb;
         held_fp  = fp_wb;
         held_int = int_wb;
      end else begin
         hold_chk = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * issued + 200) begin
         $display("Timeout after %0d cycles, %0d results outstanding", cycles, exp_q.size());
         fail_run();
      end
   end

   //--------------------------------------
   // Stimulus
   //--------------------------------------
   initial begin
      rst      <= 1'b1;
      kill     <= 1'b0;
      stall_wb <= 1'b0;
      instr    <= '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      repeat (200) issue_random_noncomp();
      foreach (cvt_vals[i])
         for (int m = 0; m < 4; m++)
            issue(CVT_I2F, {2'b00, m[0]}, m[1], cvt_vals[i], 32'd0);
      repeat (40) issue_random_cvt();

      issue(CVT_I2F, 3'd0, 1'b0, 32'd1, 32'd0);   // Longest conversion ahead of noncomp ops
      repeat (3) issue_random_noncomp();

      wb_mode = 1;
      repeat (100) begin
         if ({$random(seed)} % 4 == 0)
            issue_random_cvt();
         else
            issue_random_noncomp();
      end
      go_idle();
      drain();

      // Held writeback, the queue must fill
      wb_mode   = 2;
      saw_stall = 1'b0;
      fork
         begin
            repeat (30) @(posedge clk);
            wb_mode = 0;
         end
      join_none
      repeat (8) issue_random_noncomp();
      go_idle();
      if (!saw_stall) begin
         $display("stall_o never rose while the queue was full");
         fail_run();
      end
      drain();

      // Flush with a slow conversion at the head
      wb_mode     = 0;
      flush_start = issued;
      issue(CVT_I2F, 3'd0, 1'b1, 32'd1, 32'd0);
      repeat (2) issue_random_noncomp();
      go_idle();
      flushed = issued - flush_start;   // All three still in flight at the kill
      repeat (2) @(posedge clk);
      kill <= 1'b1;
      @(posedge clk);
      kill <= 1'b0;
      exp_q.delete();
      repeat (40) @(posedge clk);

      repeat (20) issue_random_noncomp();
      repeat (5) issue_random_cvt();
      go_idle();
      drain();
      repeat (5) @(posedge clk);
      if (retired == issued - flushed) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("Retired %0d results, expected %0d", retired, issued - flushed);
         fail_run();
      end
   end

endmodule

// File: build.f
+incdir+tests
source/fpu_pkg.sv
source/fpu_decoder.sv
source/fpu_noncomp.sv
source/fpu_i2f.sv
source/pending_fp_ops_queue.sv
source/fpu_wrapper.sv
tests/fpu_wrapper_tb.sv

// File: Makefile
# Verilator simulation of the FP execution stage

SIM  := obj_dir/Vfpu_wrapper_tb
SRCS := $(shell grep '\.sv$$' build.f) tests/fpu_ref.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fpu_wrapper_tb -f build.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
